// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_instruction_decode
FILELIST = instruction_decode.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^Everything OK$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: hdl/decode_ctrl_pkg.sv
package decode_ctrl_pkg;

   typedef logic [3:0] alu_op_t;
   typedef logic [1:0] dsize_t;

   //////////////////////////////
   // Control frames, MSB first
   //   EX   alu_op(4) b_i s_u use_shamt
   //   MEM  re we s_u dsize(2)
   //   WB   dest(5) reg_we mem_alu data_pc
   //////////////////////////////
   typedef logic [6:0] ex_ctrl_t;
   typedef logic [4:0] mem_ctrl_t;
   typedef logic [7:0] wb_ctrl_t;

   // ALU operations
   localparam alu_op_t ALU_ADD = 4'd0;
   localparam alu_op_t ALU_SUB = 4'd1;
   localparam alu_op_t ALU_AND = 4'd2;
   localparam alu_op_t ALU_OR  = 4'd3;
   localparam alu_op_t ALU_XOR = 4'd4;
   localparam alu_op_t ALU_NOR = 4'd5;
   localparam alu_op_t ALU_SRL = 4'd6;
   localparam alu_op_t ALU_SLL = 4'd7;
   localparam alu_op_t ALU_SRA = 4'd8;
   localparam alu_op_t ALU_SLT = 4'd10;
   localparam alu_op_t ALU_LUI = 4'd11;

   // Memory access sizes
   localparam dsize_t DSIZE_BYTE = 2'd0;
   localparam dsize_t DSIZE_HALF = 2'd1;
   localparam dsize_t DSIZE_WORD = 2'd2;

endpackage

// File: hdl/decode_stage_regs.sv
`timescale 1ns/1ps

module decode_stage_regs (
   input  logic                      i_clk,
   input  logic                      i_rst,
   input  logic                      i_is_rtype,
   input  logic                      i_to_ra,
   input  logic                      i_is_branch,
   input  logic                      i_branch_ne,
   input  logic                      i_jump_inm,
   input  decode_ctrl_pkg::alu_op_t  i_op_alu_op,
   input  logic                      i_b_i,
   input  logic                      i_ex_signed_u,
   input  logic                      i_mem_re,
   input  logic                      i_mem_we,
   input  logic                      i_mem_unsigned,
   input  decode_ctrl_pkg::dsize_t   i_dsize,
   input  logic                      i_reg_we,
   input  logic                      i_mem_alu,
   input  logic                      i_op_link_pc,
   input  decode_ctrl_pkg::alu_op_t  i_fn_alu_op,
   input  logic                      i_fn_use_shamt,
   input  logic                      i_fn_jump_rs,
   input  logic                      i_fn_link_pc,
   input  mips_isa_pkg::reg_addr_t   i_rt,
   input  mips_isa_pkg::reg_addr_t   i_rd,
   input  mips_isa_pkg::word_t       i_rs_data,
   input  mips_isa_pkg::word_t       i_rt_data,
   input  mips_isa_pkg::word_t       i_pc,
   output decode_ctrl_pkg::ex_ctrl_t  o_ex_ctrl,
   output decode_ctrl_pkg::mem_ctrl_t o_mem_ctrl,
   output decode_ctrl_pkg::wb_ctrl_t  o_wb_ctrl,
   output mips_isa_pkg::word_t       o_pc,
   output logic                      o_nop,
   output logic                      o_jump_rs
);
   import mips_isa_pkg::*;
   import decode_ctrl_pkg::*;

   alu_op_t   alu_op;
   reg_addr_t dest;
   logic      use_shamt;
   logic      link_pc;
   logic      branch_taken;

   // Function table only counts for R-type
   assign alu_op    = i_is_rtype ? i_fn_alu_op : i_op_alu_op;
   assign link_pc   = i_is_rtype ? i_fn_link_pc : i_op_link_pc;
   assign use_shamt = i_is_rtype & i_fn_use_shamt;
   assign o_jump_rs = i_is_rtype & i_fn_jump_rs;

   // JAL links to r31, I-type writes rt
   assign dest = i_to_ra ? RA_REG_ADDR : (i_b_i ? i_rt : i_rd);

   assign branch_taken = (i_rs_data == i_rt_data) ^ i_branch_ne;

   //////////////////////////////
   // ID/EX pipeline registers
   //////////////////////////////
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_ex_ctrl  <= '0;
         o_mem_ctrl <= '0;
         o_wb_ctrl  <= '0;
         o_pc       <= '0;
         o_nop      <= 1'b0;
      end else begin
         o_ex_ctrl  <= {alu_op, i_b_i, i_ex_signed_u, use_shamt};
         o_mem_ctrl <= {i_mem_re, i_mem_we, i_mem_unsigned, i_dsize};
         o_wb_ctrl  <= {dest, i_reg_we, i_mem_alu, link_pc};
         o_pc       <= i_pc;
         // Squash the slot after any taken redirect
         o_nop      <= o_jump_rs | i_jump_inm | (branch_taken & i_is_branch);
      end
   end

endmodule

// File: hdl/funct_decoder.sv
`timescale 1ns/1ps

module funct_decoder (
   input  mips_isa_pkg::funct_t     i_funct,
   output decode_ctrl_pkg::alu_op_t o_alu_op,
   output logic                     o_use_shamt,
   output logic                     o_jump_rs,
   output logic                     o_link_pc
);
   import mips_isa_pkg::*;
   import decode_ctrl_pkg::*;

   always_comb begin
      o_alu_op    = ALU_ADD;
      o_use_shamt = 1'b0;
      o_jump_rs   = 1'b0;
      o_link_pc   = 1'b0;

      case (i_funct)
         // Shift amount taken from the shamt field
         FN_SLL: begin
            o_alu_op    = ALU_SLL;
            o_use_shamt = 1'b1;
         end
         FN_SRL: begin
            o_alu_op    = ALU_SRL;
            o_use_shamt = 1'b1;
         end
         FN_SRA: begin
            o_alu_op    = ALU_SRA;
            o_use_shamt = 1'b1;
         end
         // Shift amount taken from rs
         FN_SLLV: o_alu_op = ALU_SLL;
         FN_SRLV: o_alu_op = ALU_SRL;
         FN_SRAV: o_alu_op = ALU_SRA;
         FN_ADDU: o_alu_op = ALU_ADD;
         FN_SUBU: o_alu_op = ALU_SUB;
         FN_AND:  o_alu_op = ALU_AND;
         FN_OR:   o_alu_op = ALU_OR;
         FN_XOR:  o_alu_op = ALU_XOR;
         FN_NOR:  o_alu_op = ALU_NOR;
         FN_SLT:  o_alu_op = ALU_SLT;
         FN_JR:   o_jump_rs = 1'b1;
         FN_JALR: begin
            o_jump_rs = 1'b1;
            o_link_pc = 1'b1;
         end
         default: begin
         end
      endcase
   end

endmodule

// File: hdl/instruction_decode.sv
`timescale 1ns/1ps

module instruction_decode (
   input  logic                          i_clk,
   input  logic                          i_rst,
   input  mips_isa_pkg::word_t           i_instruction,
   input  mips_isa_pkg::word_t           i_pc,
   input  mips_isa_pkg::reg_addr_t       i_regfile_addr,
   input  mips_isa_pkg::word_t           i_regfile_data,
   input  logic                          i_regfile_we,
   output decode_ctrl_pkg::ex_ctrl_t     o_ex_ctrl,
   output decode_ctrl_pkg::mem_ctrl_t    o_mem_ctrl,
   output decode_ctrl_pkg::wb_ctrl_t     o_wb_ctrl,
   output mips_isa_pkg::word_t           o_pc,
   output mips_isa_pkg::word_t           o_a,
   output mips_isa_pkg::word_t           o_b,
   output mips_isa_pkg::imm_t            o_inm,
   output mips_isa_pkg::shamt_t          o_shamt,
   output logic                          o_nop,
   output logic                          o_branch,
   output logic                          o_jump_rs,
   output mips_isa_pkg::word_t           o_jump_rs_addr,
   output logic                          o_jump_inm,
   output mips_isa_pkg::jump_target_t    o_jump_inm_addr
);
   import mips_isa_pkg::*;
   import decode_ctrl_pkg::*;

   opcode_t   opcode;
   funct_t    funct;
   reg_addr_t rs;
   reg_addr_t rt;
   reg_addr_t rd;

   // Opcode table outputs
   logic    is_rtype, to_ra, branch_ne, b_i, ex_signed_u;
   logic    mem_re, mem_we, mem_unsigned, reg_we, mem_alu, op_link_pc;
   alu_op_t op_alu_op;
   dsize_t  dsize;

   // Function table outputs
   alu_op_t fn_alu_op;
   logic    fn_use_shamt, fn_jump_rs, fn_link_pc;

   //////////////////////////////
   // Field extraction
   //////////////////////////////
   assign opcode          = i_instruction[OPCODE_MSB -: $bits(opcode_t)];
   assign rs              = i_instruction[RS_MSB -: $bits(reg_addr_t)];
   assign rt              = i_instruction[RT_MSB -: $bits(reg_addr_t)];
   assign rd              = i_instruction[RD_MSB -: $bits(reg_addr_t)];
   assign o_shamt         = i_instruction[SHAMT_MSB -: $bits(shamt_t)];
   assign funct           = i_instruction[FUNCT_MSB -: $bits(funct_t)];
   assign o_inm           = i_instruction[IMM_MSB -: $bits(imm_t)];
   assign o_jump_inm_addr = i_instruction[JUMP_TARGET_MSB -: $bits(jump_target_t)];

   // JR/JALR target is register rs
   assign o_jump_rs_addr = o_a;

   register_file u_register_file (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_rs_addr (rs),
      .i_rt_addr (rt),
      .i_wr_en   (i_regfile_we),
      .i_wr_addr (i_regfile_addr),
      .i_wr_data (i_regfile_data),
      .o_rs_data (o_a),
      .o_rt_data (o_b)
   );

   opcode_decoder u_opcode_decoder (
      .i_opcode       (opcode),
      .o_is_rtype     (is_rtype),
      .o_to_ra        (to_ra),
      .o_is_branch    (o_branch),
      .o_branch_ne    (branch_ne),
      .o_jump_inm     (o_jump_inm),
      .o_alu_op       (op_alu_op),
      .o_b_i          (b_i),
      .o_ex_signed_u  (ex_signed_u),
      .o_mem_re       (mem_re),
      .o_mem_we       (mem_we),
      .o_mem_unsigned (mem_unsigned),
      .o_dsize        (dsize),
      .o_reg_we       (reg_we),
      .o_mem_alu      (mem_alu),
      .o_link_pc      (op_link_pc)
   );

   funct_decoder u_funct_decoder (
      .i_funct     (funct),
      .o_alu_op    (fn_alu_op),
      .o_use_shamt (fn_use_shamt),
      .o_jump_rs   (fn_jump_rs),
      .o_link_pc   (fn_link_pc)
   );

   decode_stage_regs u_decode_stage_regs (
      .i_clk          (i_clk),
      .i_rst          (i_rst),
      .i_is_rtype     (is_rtype),
      .i_to_ra        (to_ra),
      .i_is_branch    (o_branch),
      .i_branch_ne    (branch_ne),
      .i_jump_inm     (o_jump_inm),
      .i_op_alu_op    (op_alu_op),
      .i_b_i          (b_i),
      .i_ex_signed_u  (ex_signed_u),
      .i_mem_re       (mem_re),
      .i_mem_we       (mem_we),
      .i_mem_unsigned (mem_unsigned),
      .i_dsize        (dsize),
      .i_reg_we       (reg_we),
      .i_mem_alu      (mem_alu),
      .i_op_link_pc   (op_link_pc),
      .i_fn_alu_op    (fn_alu_op),
      .i_fn_use_shamt (fn_use_shamt),
      .i_fn_jump_rs   (fn_jump_rs),
      .i_fn_link_pc   (fn_link_pc),
      .i_rt           (rt),
      .i_rd           (rd),
      .i_rs_data      (o_a),
      .i_rt_data      (o_b),
      .i_pc           (i_pc),
      .o_ex_ctrl      (o_ex_ctrl),
      .o_mem_ctrl     (o_mem_ctrl),
      .o_wb_ctrl      (o_wb_ctrl),
      .o_pc           (o_pc),
      .o_nop          (o_nop),
      .o_jump_rs      (o_jump_rs)
   );

endmodule

// File: hdl/mips_isa_pkg.sv
package mips_isa_pkg;

   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_addr_t;
   typedef logic [5:0]  opcode_t;
   typedef logic [5:0]  funct_t;
   typedef logic [15:0] imm_t;
   typedef logic [4:0]  shamt_t;
   typedef logic [25:0] jump_target_t;

   // Instruction field positions
   localparam int OPCODE_MSB      = 31;
   localparam int RS_MSB          = 25;
   localparam int RT_MSB          = 20;
   localparam int RD_MSB          = 15;
   localparam int SHAMT_MSB       = 10;
   localparam int FUNCT_MSB       = 5;
   localparam int IMM_MSB         = 15;
   localparam int JUMP_TARGET_MSB = 25;

   localparam int        REGFILE_DEPTH = 32;
   localparam reg_addr_t RA_REG_ADDR   = 5'd31;

   //////////////////////////////
   // Opcodes
   //////////////////////////////
   localparam opcode_t OP_RTYPE = 6'b000000;
   localparam opcode_t OP_LB    = 6'b100000;
   localparam opcode_t OP_LH    = 6'b100001;
   localparam opcode_t OP_LW    = 6'b100011;
   localparam opcode_t OP_LBU   = 6'b100100;
   localparam opcode_t OP_LHU   = 6'b100101;
   localparam opcode_t OP_LWU   = 6'b100111;
   localparam opcode_t OP_SB    = 6'b101000;
   localparam opcode_t OP_SH    = 6'b101001;
   localparam opcode_t OP_SW    = 6'b101011;
   localparam opcode_t OP_ADDI  = 6'b001001;
   localparam opcode_t OP_ANDI  = 6'b001100;
   localparam opcode_t OP_ORI   = 6'b001101;
   localparam opcode_t OP_XORI  = 6'b001110;
   localparam opcode_t OP_LUI   = 6'b001111;
   localparam opcode_t OP_SLTI  = 6'b001010;
   localparam opcode_t OP_BEQ   = 6'b000100;
   localparam opcode_t OP_BNE   = 6'b000101;
   localparam opcode_t OP_J     = 6'b000010;
   localparam opcode_t OP_JAL   = 6'b000011;

   //////////////////////////////
   // R-type function codes
   //////////////////////////////
   localparam funct_t FN_SLL  = 6'b000000;
   localparam funct_t FN_SRL  = 6'b000010;
   localparam funct_t FN_SRA  = 6'b000011;
   localparam funct_t FN_SLLV = 6'b000100;
   localparam funct_t FN_SRLV = 6'b000110;
   localparam funct_t FN_SRAV = 6'b000111;
   localparam funct_t FN_ADDU = 6'b100001;
   localparam funct_t FN_SUBU = 6'b100011;
   localparam funct_t FN_AND  = 6'b100100;
   localparam funct_t FN_OR   = 6'b100101;
   localparam funct_t FN_XOR  = 6'b100110;
   localparam funct_t FN_NOR  = 6'b100111;
   localparam funct_t FN_SLT  = 6'b101010;
   localparam funct_t FN_JR   = 6'b001000;
   localparam funct_t FN_JALR = 6'b001001;

endpackage

// File: hdl/opcode_decoder.sv
`timescale 1ns/1ps

module opcode_decoder (
   input  mips_isa_pkg::opcode_t   i_opcode,
   output logic                    o_is_rtype,
   output logic                    o_to_ra,
   output logic                    o_is_branch,
   output logic                    o_branch_ne,
   output logic                    o_jump_inm,
   output decode_ctrl_pkg::alu_op_t o_alu_op,
   output logic                    o_b_i,
   output logic                    o_ex_signed_u,
   output logic                    o_mem_re,
   output logic                    o_mem_we,
   output logic                    o_mem_unsigned,
   output decode_ctrl_pkg::dsize_t  o_dsize,
   output logic                    o_reg_we,
   output logic                    o_mem_alu,
   output logic                    o_link_pc
);
   import mips_isa_pkg::*;
   import decode_ctrl_pkg::*;

   always_comb begin
      // Everything off unless the opcode says otherwise
      o_is_rtype     = 1'b0;
      o_to_ra        = 1'b0;
      o_is_branch    = 1'b0;
      o_branch_ne    = 1'b0;
      o_jump_inm     = 1'b0;
      o_alu_op       = ALU_ADD;
      o_b_i          = 1'b0;
      o_ex_signed_u  = 1'b0;
      o_mem_re       = 1'b0;
      o_mem_we       = 1'b0;
      o_mem_unsigned = 1'b0;
      o_dsize        = DSIZE_BYTE;
      o_reg_we       = 1'b0;
      o_mem_alu      = 1'b0;
      o_link_pc      = 1'b0;

      case (i_opcode)
         OP_RTYPE: begin
            o_is_rtype = 1'b1;
            o_reg_we   = 1'b1;
            o_mem_alu  = 1'b1;
         end

         //////////////////////////////
         // Loads and stores
         //////////////////////////////
         OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_LWU: begin
            o_b_i          = 1'b1;
            o_mem_re       = 1'b1;
            o_reg_we       = 1'b1;
            o_mem_unsigned = (i_opcode == OP_LBU) || (i_opcode == OP_LHU) ||
                             (i_opcode == OP_LWU);
            if ((i_opcode == OP_LB) || (i_opcode == OP_LBU)) begin
               o_dsize = DSIZE_BYTE;
            end else if ((i_opcode == OP_LH) || (i_opcode == OP_LHU)) begin
               o_dsize = DSIZE_HALF;
            end else begin
               o_dsize = DSIZE_WORD;
            end
         end
         OP_SB: begin
            o_b_i    = 1'b1;
            o_mem_we = 1'b1;
            o_dsize  = DSIZE_BYTE;
         end
         OP_SH: begin
            o_b_i    = 1'b1;
            o_mem_we = 1'b1;
            o_dsize  = DSIZE_HALF;
         end
         OP_SW: begin
            o_b_i    = 1'b1;
            o_mem_we = 1'b1;
            o_dsize  = DSIZE_WORD;
         end

         //////////////////////////////
         // Immediate ALU group
         //////////////////////////////
         OP_ADDI, OP_SLTI: begin
            o_alu_op  = (i_opcode == OP_ADDI) ? ALU_ADD : ALU_SLT;
            o_b_i     = 1'b1;
            o_reg_we  = 1'b1;
            o_mem_alu = 1'b1;
         end
         OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
            case (i_opcode)
               OP_ANDI: o_alu_op = ALU_AND;
               OP_ORI:  o_alu_op = ALU_OR;
               OP_XORI: o_alu_op = ALU_XOR;
               default: o_alu_op = ALU_LUI;
            endcase
            // Logical immediates are zero extended
            o_b_i         = 1'b1;
            o_ex_signed_u = 1'b1;
            o_reg_we      = 1'b1;
            o_mem_alu     = 1'b1;
         end

         // Control flow
         OP_BEQ, OP_BNE: begin
            o_is_branch = 1'b1;
            o_branch_ne = (i_opcode == OP_BNE);
            o_b_i       = 1'b1;
         end
         OP_J: begin
            o_jump_inm = 1'b1;
         end
         OP_JAL: begin
            o_jump_inm = 1'b1;
            o_to_ra    = 1'b1;
            o_reg_we   = 1'b1;
            o_link_pc  = 1'b1;
         end
         default: begin
         end
      endcase
   end

endmodule

// File: hdl/register_file.sv
`timescale 1ns/1ps

module register_file (
   input  logic                   i_clk,
   input  logic                   i_rst,
   input  mips_isa_pkg::reg_addr_t i_rs_addr,
   input  mips_isa_pkg::reg_addr_t i_rt_addr,
   input  logic                   i_wr_en,
   input  mips_isa_pkg::reg_addr_t i_wr_addr,
   input  mips_isa_pkg::word_t     i_wr_data,
   output mips_isa_pkg::word_t     o_rs_data,
   output mips_isa_pkg::word_t     o_rt_data
);
   import mips_isa_pkg::*;

   word_t regs [REGFILE_DEPTH];

   // Asynchronous read, no bypass from the write port
   assign o_rs_data = regs[i_rs_addr];
   assign o_rt_data = regs[i_rt_addr];

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         regs <= '{default: '0};
      end else if (i_wr_en) begin
         regs[i_wr_addr] <= i_wr_data;
      end
   end

endmodule

// File: instruction_decode.f
hdl/mips_isa_pkg.sv
hdl/decode_ctrl_pkg.sv
hdl/register_file.sv
hdl/opcode_decoder.sv
hdl/funct_decoder.sv
hdl/decode_stage_regs.sv
hdl/instruction_decode.sv
testbench/tb_instruction_decode.sv

// File: testbench/tb_instruction_decode.sv
`timescale 1ns/1ps

module tb_instruction_decode;
   import mips_isa_pkg::*;
   import decode_ctrl_pkg::*;

   localparam int RESET_CYCLES   = 4;
   localparam int WRITE_CYCLES   = 64;
   localparam int OPCODE_CYCLES  = 24;
   localparam int FUNCT_CYCLES   = 19;
   localparam int BRANCH_CYCLES  = 7;
   localparam int RANDOM_CYCLES  = 2000;
   localparam int TOTAL_CYCLES   = RESET_CYCLES + WRITE_CYCLES + OPCODE_CYCLES +
                                   FUNCT_CYCLES + BRANCH_CYCLES + RANDOM_CYCLES;
   localparam int TIMEOUT_CYCLES = 2 * TOTAL_CYCLES;

   logic       i_clk = 1'b0;
   logic       i_rst;
   word_t      i_instruction;
   word_t      i_pc;
   reg_addr_t  i_regfile_addr;
   word_t      i_regfile_data;
   logic       i_regfile_we;
   ex_ctrl_t   o_ex_ctrl;
   mem_ctrl_t  o_mem_ctrl;
   wb_ctrl_t   o_wb_ctrl;
   word_t      o_pc;
   word_t      o_a;
   word_t      o_b;
   imm_t       o_inm;
   shamt_t     o_shamt;
   logic       o_nop;
   logic       o_branch;
   logic       o_jump_rs;
   word_t      o_jump_rs_addr;
   logic       o_jump_inm;
   jump_target_t o_jump_inm_addr;

   // Reference state
   word_t       model_regs [REGFILE_DEPTH];
   logic [15:0] lfsr_state  = 16'd45306;
   int          cycle_count = 0;
   string       test_name   = "reset";

   ex_ctrl_t  m_ex;
   mem_ctrl_t m_mem;
   wb_ctrl_t  m_wb;
   logic      m_branch;
   logic      m_jump_inm;
   logic      m_jump_rs;
   logic      m_nop;

   opcode_t legal_ops [20] = '{OP_RTYPE, OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_LWU,
                               OP_SB, OP_SH, OP_SW, OP_ADDI, OP_ANDI, OP_ORI, OP_XORI,
                               OP_LUI, OP_SLTI, OP_BEQ, OP_BNE, OP_J, OP_JAL};
   funct_t  legal_fns [15] = '{FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV,
                               FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR,
                               FN_SLT, FN_JR, FN_JALR};

   instruction_decode i_dut (
      .i_clk           (i_clk),
      .i_rst           (i_rst),
      .i_instruction   (i_instruction),
      .i_pc            (i_pc),
      .i_regfile_addr  (i_regfile_addr),
      .i_regfile_data  (i_regfile_data),
      .i_regfile_we    (i_regfile_we),
      .o_ex_ctrl       (o_ex_ctrl),
      .o_mem_ctrl      (o_mem_ctrl),
      .o_wb_ctrl       (o_wb_ctrl),
      .o_pc            (o_pc),
      .o_a             (o_a),
      .o_b             (o_b),
      .o_inm           (o_inm),
      .o_shamt         (o_shamt),
      .o_nop           (o_nop),
      .o_branch        (o_branch),
      .o_jump_rs       (o_jump_rs),
      .o_jump_rs_addr  (o_jump_rs_addr),
      .o_jump_inm      (o_jump_inm),
      .o_jump_inm_addr (o_jump_inm_addr)
   );

   always #20 i_clk = ~i_clk;

   always @(posedge i_clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_count > TIMEOUT_CYCLES) begin
         $display("Timeout after %0d cycles, the test sequence never completed", cycle_count);
         $display("Something failed");
         $fatal(1);
      end
   end

   //////////////////////////////
   // Random source
   //////////////////////////////
   function automatic word_t random_bits(input int n);
      word_t v;
      int    k;
      v = '0;
      for (k = 0; k < n; k++) begin
         if (lfsr_state[0]) begin
            lfsr_state = (lfsr_state >> 1) ^ 16'hB400;
         end else begin
            lfsr_state = lfsr_state >> 1;
         end
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   // Mostly legal, R-type favoured, a few from the unused 11xxxx space
   function automatic opcode_t pick_opcode();
      logic [4:0] r;
      r = 5'(random_bits(5));
      if (r < 5'd20) begin
         return legal_ops[r];
      end else if (r < 5'd23) begin
         return {2'b11, 4'(random_bits(4))};
      end else begin
         return OP_RTYPE;
      end
   endfunction

   function automatic funct_t pick_funct();
      logic [3:0] r;
      r = 4'(random_bits(4));
      if (r < 4'd15) begin
         return legal_fns[r];
      end else begin
         return {2'b11, 4'(random_bits(4))};
      end
   endfunction

   //////////////////////////////
   // Reference decode
   //////////////////////////////
   // Access size from the two low opcode bits of loads and stores
   function automatic dsize_t size_code(input logic [1:0] low);
      case (low)
         2'b00:   return DSIZE_BYTE;
         2'b01:   return DSIZE_HALF;
         default: return DSIZE_WORD;
      endcase
   endfunction

   task automatic model_decode(input word_t instr, input word_t a, input word_t b);
      opcode_t   op;
      funct_t    fn;
      logic      rtype, to_ra, is_br, br_ne, j_inm, b_i, s_u;
      logic      re, mwe, mu, rwe, malu, op_lpc;
      logic      fn_shamt, fn_jrs, fn_lpc, taken;
      alu_op_t   op_alu;
      alu_op_t   fn_alu;
      dsize_t    ds;
      reg_addr_t dest;
      op = instr[31:26];
      fn = instr[5:0];
      {rtype, to_ra, is_br, br_ne, j_inm, b_i, s_u} = '0;
      {re, mwe, mu, rwe, malu, op_lpc} = '0;
      op_alu = ALU_ADD;
      ds     = DSIZE_BYTE;
      case (op)
         OP_RTYPE: {rtype, rwe, malu} = 3'b111;
         OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_LWU: begin
            {b_i, re, rwe} = 3'b111;
            mu = op[2];
            ds = size_code(op[1:0]);
         end
         OP_SB, OP_SH, OP_SW: begin
            {b_i, mwe} = 2'b11;
            ds = size_code(op[1:0]);
         end
         OP_ADDI: {b_i, rwe, malu} = 3'b111;
         OP_SLTI: begin
            op_alu = ALU_SLT;
            {b_i, rwe, malu} = 3'b111;
         end
         OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
            case (op[1:0])
               2'b00:   op_alu = ALU_AND;
               2'b01:   op_alu = ALU_OR;
               2'b10:   op_alu = ALU_XOR;
               default: op_alu = ALU_LUI;
            endcase
            {b_i, s_u, rwe, malu} = 4'b1111;
         end
         OP_BEQ: {is_br, b_i} = 2'b11;
         OP_BNE: {is_br, br_ne, b_i} = 3'b111;
         OP_J:   j_inm = 1'b1;
         OP_JAL: {j_inm, to_ra, rwe, op_lpc} = 4'b1111;
         default: begin
         end
      endcase

      case (fn)
         FN_SLL, FN_SLLV: fn_alu = ALU_SLL;
         FN_SRL, FN_SRLV: fn_alu = ALU_SRL;
         FN_SRA, FN_SRAV: fn_alu = ALU_SRA;
         FN_SUBU:         fn_alu = ALU_SUB;
         FN_AND:          fn_alu = ALU_AND;
         FN_OR:           fn_alu = ALU_OR;
         FN_XOR:          fn_alu = ALU_XOR;
         FN_NOR:          fn_alu = ALU_NOR;
         FN_SLT:          fn_alu = ALU_SLT;
         default:         fn_alu = ALU_ADD;
      endcase
      fn_shamt = (fn == FN_SLL) || (fn == FN_SRL) || (fn == FN_SRA);
      fn_jrs   = (fn == FN_JR) || (fn == FN_JALR);
      fn_lpc   = (fn == FN_JALR);

      // Function table only matters for R-type
      dest       = to_ra ? 5'd31 : (b_i ? instr[20:16] : instr[15:11]);
      taken      = (a == b) != br_ne;
      m_jump_rs  = rtype & fn_jrs;
      m_jump_inm = j_inm;
      m_branch   = is_br;
      m_ex       = {(rtype ? fn_alu : op_alu), b_i, s_u, rtype & fn_shamt};
      m_mem      = {re, mwe, mu, ds};
      m_wb       = {dest, rwe, malu, (rtype ? fn_lpc : op_lpc)};
      m_nop      = m_jump_rs | j_inm | (is_br & taken);
   endtask

   task automatic check_value(input string what, input word_t expected, input word_t actual);
      if (expected !== actual) begin
         $display("Fail %s %s: expected %h actual %h", test_name, what, expected, actual);
         $display("Something failed");
         $fatal(1);
      end
   endtask

   //////////////////////////////
   // One decode cycle
   //////////////////////////////
   // Called 1 ns after a rising edge, returns 1 ns after the next one
   task automatic run_cycle(input word_t instr, input word_t pc, input logic we,
                            input reg_addr_t waddr, input word_t wdata);
      word_t a;
      word_t b;
      i_instruction  = instr;
      i_pc           = pc;
      i_regfile_we   = we;
      i_regfile_addr = waddr;
      i_regfile_data = wdata;
      a = model_regs[instr[25:21]];
      b = model_regs[instr[20:16]];
      model_decode(instr, a, b);
      #10;
      check_value("o_a", a, o_a);
      check_value("o_b", b, o_b);
      check_value("o_jump_rs_addr", a, o_jump_rs_addr);
      check_value("o_inm", 32'(instr[15:0]), 32'(o_inm));
      check_value("o_shamt", 32'(instr[10:6]), 32'(o_shamt));
      check_value("o_jump_inm_addr", 32'(instr[25:0]), 32'(o_jump_inm_addr));
      check_value("o_branch", 32'(m_branch), 32'(o_branch));
      check_value("o_jump_rs", 32'(m_jump_rs), 32'(o_jump_rs));
      check_value("o_jump_inm", 32'(m_jump_inm), 32'(o_jump_inm));
      @(posedge i_clk);
      #1;
      if (we) begin
         model_regs[waddr] = wdata;
      end
      check_value("o_ex_ctrl", 32'(m_ex), 32'(o_ex_ctrl));
      check_value("o_mem_ctrl", 32'(m_mem), 32'(o_mem_ctrl));
      check_value("o_wb_ctrl", 32'(m_wb), 32'(o_wb_ctrl));
      check_value("o_pc", pc, o_pc);
      check_value("o_nop", 32'(m_nop), 32'(o_nop));
   endtask

   task automatic drive_random(input word_t instr);
      word_t     pc;
      logic      we;
      reg_addr_t waddr;
      word_t     wdata;
      pc    = random_bits(32);
      we    = 1'(random_bits(1));
      waddr = 5'(random_bits(5));
      wdata = random_bits(32);
      run_cycle(instr, pc, we, waddr, wdata);
   endtask

   task automatic branch_cycle(input opcode_t op, input reg_addr_t rs, input reg_addr_t rt);
      word_t instr;
      word_t pc;
      instr          = random_bits(32);
      instr[31:26]   = op;
      instr[25:21]   = rs;
      instr[20:16]   = rt;
      pc             = random_bits(32);
      run_cycle(instr, pc, 1'b0, '0, '0);
   endtask

   initial begin
      int        i;
      word_t     instr;
      word_t     pc;
      word_t     wdata;
      word_t     value;
      reg_addr_t waddr;
      reg_addr_t prev_addr;
      reg_addr_t ra;
      reg_addr_t rb;
      reg_addr_t rc;

      i_rst          = 1'b1;
      i_instruction  = '0;
      i_pc           = '0;
      i_regfile_we   = 1'b0;
      i_regfile_addr = '0;
      i_regfile_data = '0;
      for (i = 0; i < REGFILE_DEPTH; i++) begin
         model_regs[i] = '0;
      end
      repeat (RESET_CYCLES) @(posedge i_clk);
      #1;
      i_rst = 1'b0;
      check_value("o_ex_ctrl", '0, 32'(o_ex_ctrl));
      check_value("o_mem_ctrl", '0, 32'(o_mem_ctrl));
      check_value("o_wb_ctrl", '0, 32'(o_wb_ctrl));
      check_value("o_pc", '0, o_pc);
      check_value("o_nop", '0, 32'(o_nop));

      // Each cycle reads back the register written one cycle before
      test_name = "regfile_write";
      prev_addr = 5'(random_bits(5));
      for (i = 0; i < WRITE_CYCLES; i++) begin
         instr        = random_bits(32);
         instr[25:21] = prev_addr;
         pc           = random_bits(32);
         waddr        = 5'(random_bits(5));
         wdata        = random_bits(32);
         run_cycle(instr, pc, 1'b1, waddr, wdata);
         prev_addr = waddr;
      end

      test_name = "opcode_table";
      for (i = 0; i < OPCODE_CYCLES; i++) begin
         instr = random_bits(32);
         if (i < 20) begin
            instr[31:26] = legal_ops[i];
         end else begin
            instr[31:26] = {2'b11, 4'(random_bits(4))};
         end
         drive_random(instr);
      end

      test_name = "funct_table";
      for (i = 0; i < 16; i++) begin
         instr        = random_bits(32);
         instr[31:26] = OP_RTYPE;
         instr[5:0]   = (i < 15) ? legal_fns[i] : 6'b111111;
         drive_random(instr);
      end

      // Jump-register codes under other opcodes
      test_name = "jr_gating";
      instr = random_bits(32);
      instr[31:26] = OP_ADDI;
      instr[5:0]   = FN_JR;
      drive_random(instr);
      instr = random_bits(32);
      instr[31:26] = OP_BEQ;
      instr[5:0]   = FN_JALR;
      drive_random(instr);
      instr = random_bits(32);
      instr[31:26] = {2'b11, 4'(random_bits(4))};
      instr[5:0]   = FN_JR;
      drive_random(instr);

      // ra and rb equal, rc differs
      test_name = "branch";
      ra    = 5'(random_bits(5));
      rb    = ra + 5'd1;
      rc    = ra + 5'd2;
      value = random_bits(32);
      run_cycle(random_bits(32), random_bits(32), 1'b1, ra, value);
      run_cycle(random_bits(32), random_bits(32), 1'b1, rb, value);
      run_cycle(random_bits(32), random_bits(32), 1'b1, rc, value ^ (random_bits(32) | 1));
      branch_cycle(OP_BEQ, ra, rb);
      branch_cycle(OP_BEQ, ra, rc);
      branch_cycle(OP_BNE, ra, rb);
      branch_cycle(OP_BNE, ra, rc);

      test_name = "random";
      for (i = 0; i < RANDOM_CYCLES; i++) begin
         instr        = random_bits(32);
         instr[31:26] = pick_opcode();
         instr[5:0]   = pick_funct();
         drive_random(instr);
      end

      $display("Everything OK");
      $finish;
   end

endmodule
